//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = spi_bridge_tb
FILELIST  = spi_bridge.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf $(OBJ_DIR)

//--- design/byte_ram.sv
`default_nettype none

module byte_ram
    import spi_bridge_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  bus_req_t          bus_req_i,
    input  logic              bus_cycle_i,
    output logic              bus_ack_o,
    output logic [DATA_W-1:0] bus_rdata_o
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic              ack_q;
    logic [DATA_W-1:0] rdata_q;

    // Four-phase target handshake
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else if (bus_cycle_i && !ack_q) begin
            ack_q <= 1'b1;
        end else if (!bus_cycle_i && ack_q) begin
            ack_q <= 1'b0;                  // Release once cycle drops
        end
    end

    // Access happens on the edge that raises ack
    always_ff @(posedge clk) begin
        if (bus_cycle_i && !ack_q) begin
            if (bus_req_i.we) begin
                mem[bus_req_i.addr] <= bus_req_i.wdata;
            end else begin
                rdata_q <= mem[bus_req_i.addr];
            end
        end
    end

    assign bus_ack_o   = ack_q;
    assign bus_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- design/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

    localparam int ADDR_W    = 17;          // 128 KiB address map
    localparam int DATA_W    = 8;
    localparam int MEM_DEPTH = 131072;

    // Opcode lives in bits 7:5 of the command byte
    typedef enum logic [2:0] {
        OP_WRITE_AT  = 3'b001,
        OP_READ_AT   = 3'b010,
        OP_READ_NEXT = 3'b011
    } spi_opcode_e;

    typedef enum logic [2:0] {
        CMD,
        ADDR_HI,
        ADDR_LO,
        DATA,
        BUS,                                // Bus cycle pending, host stalled
        REPLY,
        IGNORE                              // Wait for CS_N to rise
    } cmd_state_e;

    // Pin events, all in the clk domain
    typedef struct packed {
        logic sck_rise;
        logic sck_fall;
        logic frame_start;                  // CS_N fell
        logic frame_end;                    // CS_N rose
        logic sdi;                          // Synchronized PICO level
    } spi_event_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              we;
    } bus_req_t;

endpackage

`default_nettype wire

//--- design/spi_bridge_top.sv
`default_nettype none

module spi_bridge_top
    import spi_bridge_pkg::*;
(
    input  logic clk,
    input  logic rst_n_i,
    input  logic spi_sck_i,
    input  logic spi_cs_n_i,
    input  logic spi_pico_i,
    output logic spi_poci_o,
    output logic spi_stall_o
);

    spi_event_t        events;
    bus_req_t          bus_req;
    logic              bus_cycle;
    logic              bus_ack;
    logic [DATA_W-1:0] bus_rdata;

    spi_pin_sync u_sync (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .spi_sck_i  (spi_sck_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_pico_i (spi_pico_i),
        .events_o   (events)
    );

    spi_command_engine u_engine (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .events_i    (events),
        .bus_req_o   (bus_req),
        .bus_cycle_o (bus_cycle),
        .bus_ack_i   (bus_ack),
        .bus_rdata_i (bus_rdata),
        .spi_poci_o  (spi_poci_o),
        .spi_stall_o (spi_stall_o)
    );

    byte_ram u_ram (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .bus_req_i   (bus_req),
        .bus_cycle_i (bus_cycle),
        .bus_ack_o   (bus_ack),
        .bus_rdata_o (bus_rdata)
    );

endmodule

`default_nettype wire

//--- design/spi_command_engine.sv
`default_nettype none

module spi_command_engine
    import spi_bridge_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  spi_event_t        events_i,
    output bus_req_t          bus_req_o,
    output logic              bus_cycle_o,
    input  logic              bus_ack_i,
    input  logic [DATA_W-1:0] bus_rdata_i,
    output logic              spi_poci_o,
    output logic              spi_stall_o
);

    cmd_state_e        state_q;
    spi_opcode_e       opcode_q;
    spi_opcode_e       rx_opcode;
    logic [2:0]        bit_cnt_q;
    logic [6:0]        shift_in_q;
    logic [DATA_W-1:0] rx_byte;
    logic              byte_done;
    logic              start_bus;
    logic [ADDR_W-1:0] addr_stage_q;    // Address being assembled in a frame
    bus_req_t          req_q;           // Holds the last accessed address
    logic              cycle_q;
    logic              ack_seen_q;
    logic              stall_q;
    logic [DATA_W-1:0] poci_shift_q;

    assign rx_byte   = {shift_in_q, events_i.sdi};
    assign rx_opcode = spi_opcode_e'(rx_byte[7:5]);
    assign byte_done = events_i.sck_rise && (bit_cnt_q == 3'd7) && (state_q != BUS);

    // The last bit of a complete command launches the bus cycle
    always_comb begin
        start_bus = 1'b0;
        if (byte_done) begin
            case (state_q)
                CMD:     start_bus = (rx_opcode == OP_READ_NEXT);
                ADDR_LO: start_bus = (opcode_q == OP_READ_AT);
                DATA:    start_bus = 1'b1;
                default: start_bus = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= CMD;
            bit_cnt_q    <= '0;
            cycle_q      <= 1'b0;
            ack_seen_q   <= 1'b0;
            stall_q      <= 1'b0;
            poci_shift_q <= '0;
        end else if (events_i.frame_end || events_i.frame_start) begin
            // Abort whatever is unfinished
            state_q      <= CMD;
            bit_cnt_q    <= '0;
            cycle_q      <= 1'b0;
            ack_seen_q   <= 1'b0;
            stall_q      <= 1'b0;
            poci_shift_q <= '0;
        end else begin
            if (events_i.sck_rise && state_q != BUS) begin  // Edges under stall dropped
                bit_cnt_q  <= bit_cnt_q + 3'd1;
                shift_in_q <= rx_byte[6:0];
            end

            case (state_q)
                CMD: begin
                    if (byte_done) begin
                        opcode_q         <= rx_opcode;
                        addr_stage_q[16] <= rx_byte[0];
                        case (rx_opcode)
                            OP_WRITE_AT, OP_READ_AT: state_q <= ADDR_HI;
                            OP_READ_NEXT: begin
                                req_q.addr <= req_q.addr + 1'b1;  // Carry into bit 16
                                req_q.we   <= 1'b0;
                            end
                            default: state_q <= IGNORE;
                        endcase
                    end
                end
                ADDR_HI: begin
                    if (byte_done) begin
                        addr_stage_q[15:8] <= rx_byte;
                        state_q            <= ADDR_LO;
                    end
                end
                ADDR_LO: begin
                    if (byte_done) begin
                        if (opcode_q == OP_WRITE_AT) begin
                            addr_stage_q[7:0] <= rx_byte;
                            state_q           <= DATA;
                        end else begin
                            req_q.addr <= {addr_stage_q[16:8], rx_byte};
                            req_q.we   <= 1'b0;
                        end
                    end
                end
                DATA: begin
                    if (byte_done) begin
                        req_q.addr  <= addr_stage_q;
                        req_q.wdata <= rx_byte;
                        req_q.we    <= 1'b1;
                    end
                end
                BUS: begin
                    if (!cycle_q && !ack_seen_q && !bus_ack_i) begin
                        cycle_q <= 1'b1;                // Late start after previous ack
                    end else if (cycle_q && bus_ack_i && !ack_seen_q) begin
                        ack_seen_q <= 1'b1;
                        if (!req_q.we) begin
                            poci_shift_q <= bus_rdata_i;
                        end
                    end else if (ack_seen_q) begin
                        cycle_q    <= 1'b0;
                        stall_q    <= 1'b0;             // Host may clock again
                        ack_seen_q <= 1'b0;
                        state_q    <= req_q.we ? IGNORE : REPLY;
                    end
                end
                REPLY: begin
                    if (events_i.sck_fall) begin
                        poci_shift_q <= {poci_shift_q[6:0], 1'b0};  // Next bit after fall
                    end
                    if (byte_done) begin
                        state_q <= IGNORE;
                    end
                end
                default: ;                              // IGNORE waits for CS_N
            endcase

            if (start_bus) begin
                cycle_q    <= !bus_ack_i;   // No new cycle while ack is high
                stall_q    <= 1'b1;
                ack_seen_q <= 1'b0;
                state_q    <= BUS;
            end
        end
    end

    assign bus_req_o   = req_q;
    assign bus_cycle_o = cycle_q;
    assign spi_stall_o = stall_q;
    assign spi_poci_o  = poci_shift_q[7];   // MSB first

endmodule

`default_nettype wire

//--- design/spi_pin_sync.sv
`default_nettype none

module spi_pin_sync
    import spi_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       spi_sck_i,
    input  logic       spi_cs_n_i,
    input  logic       spi_pico_i,
    output spi_event_t events_o
);

    logic sck_s1_q;
    logic sck_s2_q;
    logic sck_s3_q;
    logic cs_n_s1_q;
    logic cs_n_s2_q;
    logic cs_n_s3_q;
    logic pico_s1_q;
    logic pico_s2_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sck_s1_q  <= 1'b0;
            sck_s2_q  <= 1'b0;
            sck_s3_q  <= 1'b0;
            cs_n_s1_q <= 1'b1;              // Idle high, no false frame start
            cs_n_s2_q <= 1'b1;
            cs_n_s3_q <= 1'b1;
            pico_s1_q <= 1'b0;
            pico_s2_q <= 1'b0;
        end else begin
            sck_s1_q  <= spi_sck_i;
            sck_s2_q  <= sck_s1_q;
            sck_s3_q  <= sck_s2_q;          // Edge detect stage
            cs_n_s1_q <= spi_cs_n_i;
            cs_n_s2_q <= cs_n_s1_q;
            cs_n_s3_q <= cs_n_s2_q;
            pico_s1_q <= spi_pico_i;
            pico_s2_q <= pico_s1_q;
        end
    end

    // SCK edges only count while the frame is selected
    always_comb begin
        events_o.sck_rise    = sck_s2_q & ~sck_s3_q & ~cs_n_s2_q;
        events_o.sck_fall    = ~sck_s2_q & sck_s3_q & ~cs_n_s2_q;
        events_o.frame_start = ~cs_n_s2_q & cs_n_s3_q;
        events_o.frame_end   = cs_n_s2_q & ~cs_n_s3_q;
        events_o.sdi         = pico_s2_q;   // Same delay as the SCK path
    end

endmodule

`default_nettype wire

//--- spi_bridge.f
design/spi_bridge_pkg.sv
design/spi_pin_sync.sv
design/spi_command_engine.sv
design/byte_ram.sv
design/spi_bridge_top.sv
test/spi_host_model.sv
test/spi_bridge_tb.sv

//--- test/spi_bridge_tb.sv
`default_nettype none

module spi_bridge_tb
    import spi_bridge_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst_n;
    logic              spi_sck;
    logic              spi_cs_n;
    logic              spi_pico;
    logic              spi_poci;
    logic              spi_stall;
    logic              host_timeout;

    logic [7:0]        mem_model [int];     // Bytes written so far
    logic [ADDR_W-1:0] last_addr;           // Address of the previous access
    integer            seed = 32'h52b559d8;
    int                check_errors;
    int                protocol_errors;
    int                tests_passed;
    int                tests_failed;
    int                stall_clocks;
    int                cs_high_clocks;
    int                stall_rises;
    logic              stall_prev;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    spi_bridge_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .spi_sck_i   (spi_sck),
        .spi_cs_n_i  (spi_cs_n),
        .spi_pico_i  (spi_pico),
        .spi_poci_o  (spi_poci),
        .spi_stall_o (spi_stall)
    );

    spi_host_model u_host (
        .clk         (clk),
        .spi_poci_i  (spi_poci),
        .spi_stall_i (spi_stall),
        .spi_sck_o   (spi_sck),
        .spi_cs_n_o  (spi_cs_n),
        .spi_pico_o  (spi_pico),
        .timeout_o   (host_timeout)
    );

    sck_still_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n) spi_stall |-> $stable(spi_sck)
    ) else begin
        $display("** Error at %0t: SCK changed while stall was high", $time);
        protocol_errors++;
    end

    // Stall length and release after CS_N rises
    always @(posedge clk) begin
        if (!rst_n) begin
            stall_clocks   <= 0;
            cs_high_clocks <= 0;
            stall_prev     <= 1'b0;
        end else begin
            assert (!(spi_stall && stall_clocks >= 3)) else begin
                $display("** Error at %0t: stall high for more than 3 clocks", $time);
                protocol_errors++;
            end
            assert (!(spi_stall && cs_high_clocks >= 4)) else begin
                $display("** Error at %0t: stall still high 4 clocks after CS_N rose", $time);
                protocol_errors++;
            end
            if (spi_stall && !stall_prev) begin
                stall_rises++;
            end
            stall_clocks   <= spi_stall ? stall_clocks + 1 : 0;
            cs_high_clocks <= spi_cs_n ? cs_high_clocks + 1 : 0;
            stall_prev     <= spi_stall;
        end
    end

    always @(posedge clk) begin
        if (host_timeout) begin
            $display("Run stopped because the SPI host timed out waiting for stall");
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic compare_read(input logic [ADDR_W-1:0] addr, input logic [7:0] got);
        logic [7:0] expected;
        expected = mem_model.exists(int'(addr)) ? mem_model[int'(addr)] : 8'hxx;
        assert (got === expected) else begin
            $display("** Error at %0t: read of 0x%05h returned 0x%02h, expected 0x%02h",
                     $time, addr, got, expected);
            check_errors++;
        end
    endtask

    task automatic store_byte(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
        u_host.write_at(addr, data);
        mem_model[int'(addr)] = data;
        last_addr = addr;
    endtask

    task automatic fetch_at(input logic [ADDR_W-1:0] addr);
        logic [7:0] got;
        u_host.read_at(addr, got);
        last_addr = addr;
        compare_read(addr, got);
    endtask

    task automatic fetch_next();
        logic [7:0] got;
        u_host.read_next(got);
        last_addr = last_addr + 17'd1;      // Wraps at 128 KiB
        compare_read(last_addr, got);
    endtask

    task automatic report_test(input string name, input int new_errors);
        if (new_errors == 0) begin
            tests_passed++;
            $display("Test %s passed at %0t", name, $time);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, new_errors);
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;
        int                errors_before;

        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        errors_before = check_errors + protocol_errors;
        assert (spi_stall === 1'b0 && spi_poci === 1'b0) else begin
            $display("** Error at %0t: stall=%b poci=%b after reset, expected both low",
                     $time, spi_stall, spi_poci);
            check_errors++;
        end
        report_test("reset_outputs", check_errors + protocol_errors - errors_before);

        errors_before = check_errors + protocol_errors;
        for (int i = 0; i < 8; i++) begin
            addr = ADDR_W'($random(seed));
            store_byte(addr, 8'($random(seed)));
            fetch_at(addr);
        end
        report_test("write_then_read", check_errors + protocol_errors - errors_before);

        errors_before = check_errors + protocol_errors;
        for (int i = 0; i < 4; i++) begin
            store_byte(17'h0FFFE + ADDR_W'(i), 8'($random(seed)));
        end
        fetch_at(17'h0FFFE);
        repeat (3) fetch_next();            // Crosses into bit 16
        report_test("read_next_carry", check_errors + protocol_errors - errors_before);

        errors_before = check_errors + protocol_errors;
        addr = ADDR_W'($random(seed));
        data = 8'($random(seed));
        store_byte(addr, data);
        store_byte(addr ^ 17'h00001, ~data);    // Bridge now holds other write data
        u_host.abort_write(addr);
        fetch_at(addr);                     // Old byte must survive
        report_test("aborted_write", check_errors + protocol_errors - errors_before);

        errors_before = check_errors;
        assert (stall_rises > 0) else begin
            $display("No stall was seen during the run, so the stall checks never ran");
            check_errors++;
        end
        report_test("stall_timing", protocol_errors + check_errors - errors_before);

        $display("Summary: %0d tests passed, %0d failed, %0d check errors, %0d protocol errors",
                 tests_passed, tests_failed, check_errors, protocol_errors);
        if (tests_failed == 0 && check_errors == 0 && protocol_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/spi_host_model.sv
`default_nettype none

module spi_host_model
    import spi_bridge_pkg::*;
(
    input  logic clk,
    input  logic spi_poci_i,
    input  logic spi_stall_i,
    output logic spi_sck_o,
    output logic spi_cs_n_o,
    output logic spi_pico_o,
    output logic timeout_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SCK_HIGH      = 2;       // Fall lands inside the bus cycle
    localparam int SCK_LOW       = 14;      // SCK period is 16 clocks
    localparam int STALL_TIMEOUT = 200;

    initial begin
        spi_sck_o  = 1'b0;
        spi_cs_n_o = 1'b1;
        spi_pico_o = 1'b0;
        timeout_o  = 1'b0;
    end

    task automatic wait_stall_low();
        int waited;
        waited = 0;
        while (spi_stall_i && waited < STALL_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (spi_stall_i) begin
            $display("SPI host gave up at %0t: stall stayed high for %0d clocks",
                     $time, STALL_TIMEOUT);
            timeout_o <= 1'b1;
        end
    endtask

    task automatic shift_bit(input logic tx_bit, output logic rx_bit);
        @(posedge clk);
        spi_pico_o <= tx_bit;               // Change one clock after the fall
        repeat (SCK_LOW - 2) @(posedge clk);
        wait_stall_low();
        @(posedge clk);
        rx_bit = spi_poci_i;                // Sample on the rising edge
        spi_sck_o <= 1'b1;
        repeat (SCK_HIGH) @(posedge clk);
        spi_sck_o <= 1'b0;
    endtask

    task automatic shift_byte(input logic [7:0] tx_byte, output logic [7:0] rx_byte);
        logic rx_bit;
        for (int i = 7; i >= 0; i--) begin  // MSB first
            shift_bit(tx_byte[i], rx_bit);
            rx_byte[i] = rx_bit;
        end
    endtask

    task automatic start_frame();
        @(posedge clk);
        spi_cs_n_o <= 1'b0;
    endtask

    task automatic finish_frame();
        repeat (SCK_LOW) @(posedge clk);
        wait_stall_low();
        spi_cs_n_o <= 1'b1;
        repeat (8) @(posedge clk);          // Let frame_end reach the engine
    endtask

    task automatic write_at(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
        logic [7:0] ignored;
        start_frame();
        shift_byte({OP_WRITE_AT, 4'b0000, addr[16]}, ignored);
        shift_byte(addr[15:8], ignored);
        shift_byte(addr[7:0], ignored);
        shift_byte(data, ignored);
        finish_frame();
    endtask

    task automatic read_at(input logic [ADDR_W-1:0] addr, output logic [7:0] data);
        logic [7:0] ignored;
        start_frame();
        shift_byte({OP_READ_AT, 4'b0000, addr[16]}, ignored);
        shift_byte(addr[15:8], ignored);
        shift_byte(addr[7:0], ignored);
        shift_byte(8'h00, data);            // Reply byte after the stall
        finish_frame();
    endtask

    task automatic read_next(output logic [7:0] data);
        logic [7:0] ignored;
        start_frame();
        shift_byte({OP_READ_NEXT, 5'b00000}, ignored);
        shift_byte(8'h00, data);
        finish_frame();
    endtask

    // Write-at cut short after the address bytes
    task automatic abort_write(input logic [ADDR_W-1:0] addr);
        logic [7:0] ignored;
        start_frame();
        shift_byte({OP_WRITE_AT, 4'b0000, addr[16]}, ignored);
        shift_byte(addr[15:8], ignored);
        shift_byte(addr[7:0], ignored);
        finish_frame();
    endtask

endmodule

`default_nettype wire
